//--- rtl/sd_adma_desc_reg.sv
`default_nettype none

module sd_adma_desc_reg (
  input  wire                                       clock,
  input  wire                                       reset,
  input  wire                                       fetch_req,
  input  wire                                       beat_valid,
  input  wire sd_adma_pkg::word_t                   beat_data,
  output logic                                      desc_valid,
  output logic                                      desc_end,
  output logic [sd_adma_pkg::DESC_ACT_W-1:0]        desc_act,
  output sd_adma_pkg::byte_len_t                    desc_len,
  output sd_adma_pkg::addr_t                        desc_addr
);

  logic [1:0]                             beat_ptr;
  logic                                   beat_take;
  sd_adma_pkg::desc_t                     desc_line;
  logic [sd_adma_pkg::DESC_LEN_W-1:0]     len_field;

  // Stops at two so a stray third beat cannot disturb the line
  assign beat_take = beat_valid && (beat_ptr != 2'(sd_adma_pkg::DESC_BEATS));

  always_ff @(posedge clock) begin
    if (!reset) begin
      beat_ptr <= 2'd0;
    end else if (fetch_req) begin
      beat_ptr <= 2'd0;
    end else if (beat_take) begin
      beat_ptr <= beat_ptr + 2'd1;
    end
  end

  // Attribute word arrives first and ends up in the low half
  always_ff @(posedge clock) begin
    if (beat_take) begin
      desc_line <= {beat_data, desc_line[63:32]};
    end
  end

  ////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////

  assign len_field  = desc_line[sd_adma_pkg::DESC_LEN_LSB +: sd_adma_pkg::DESC_LEN_W];

  assign desc_valid = desc_line[sd_adma_pkg::DESC_VALID_BIT];
  assign desc_end   = desc_line[sd_adma_pkg::DESC_END_BIT];
  assign desc_act   = desc_line[sd_adma_pkg::DESC_ACT_LSB +: sd_adma_pkg::DESC_ACT_W];
  assign desc_addr  = desc_line[sd_adma_pkg::DESC_ADDR_LSB +: $bits(sd_adma_pkg::addr_t)];

  // A zero length field means 64 KB
  assign desc_len   = (len_field == '0) ? 17'h1_0000 : {1'b0, len_field};

endmodule

`default_nettype wire

//--- rtl/sd_adma_fsm.sv
`default_nettype none

module sd_adma_fsm (
  input  wire                                       clock,
  input  wire                                       reset,
  input  wire                                       start,
  input  wire sd_adma_pkg::addr_t                   start_pointer,
  input  wire                                       int_clear,
  input  wire                                       done,
  input  wire                                       desc_valid,
  input  wire                                       desc_end,
  input  wire [sd_adma_pkg::DESC_ACT_W-1:0]         desc_act,
  input  wire sd_adma_pkg::byte_len_t               desc_len,
  input  wire sd_adma_pkg::addr_t                   desc_addr,
  output logic                                      fetch_req,
  output sd_adma_pkg::addr_t                        fetch_addr,
  output logic                                      xfer_req,
  output sd_adma_pkg::addr_t                        xfer_addr,
  output sd_adma_pkg::byte_len_t                    xfer_bytes,
  output logic [1:0]                                dma_int
);

  sd_adma_pkg::adma_state_t state;
  sd_adma_pkg::addr_t       desc_ptr;
  logic                     is_tran;
  logic                     is_link;

  assign is_tran = (desc_act == sd_adma_pkg::ACT_TRAN);
  assign is_link = (desc_act == sd_adma_pkg::ACT_LINK);

  // Fetch address follows the descriptor pointer
  assign fetch_addr = desc_ptr;

  // Transfer parameters come straight from the current descriptor
  assign xfer_addr  = desc_addr;
  assign xfer_bytes = desc_len;

  ////////////////////////////////////////
  // Descriptor walk
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state     <= sd_adma_pkg::st_stop;
      desc_ptr  <= '0;
      fetch_req <= 1'b0;
      xfer_req  <= 1'b0;
      dma_int   <= 2'b00;
    end else begin
      fetch_req <= 1'b0;
      xfer_req  <= 1'b0;

      case (state)
        sd_adma_pkg::st_stop: begin
          if (start) begin
            desc_ptr  <= start_pointer;
            fetch_req <= 1'b1;
            state     <= sd_adma_pkg::st_fds;
          end
        end

        sd_adma_pkg::st_fds: begin
          if (done) begin
            if (desc_valid) begin
              state <= sd_adma_pkg::st_cadr;
            end else begin
              // Invalid descriptor, error and stop
              dma_int[1] <= 1'b1;
              state      <= sd_adma_pkg::st_stop;
            end
          end
        end

        sd_adma_pkg::st_cadr: begin
          if (is_link) begin
            desc_ptr <= desc_addr;
          end else begin
            desc_ptr <= desc_ptr + sd_adma_pkg::addr_t'(sd_adma_pkg::DESC_STRIDE);
          end

          if (is_tran) begin
            xfer_req <= 1'b1;
            state    <= sd_adma_pkg::st_tfr;
          end else if (desc_end) begin
            dma_int[0] <= 1'b1;
            state      <= sd_adma_pkg::st_stop;
          end else begin
            // Pointer above is already updated when this fetch starts
            fetch_req <= 1'b1;
            state     <= sd_adma_pkg::st_fds;
          end
        end

        sd_adma_pkg::st_tfr: begin
          if (done) begin
            if (desc_end) begin
              dma_int[0] <= 1'b1;
              state      <= sd_adma_pkg::st_stop;
            end else begin
              fetch_req <= 1'b1;
              state     <= sd_adma_pkg::st_fds;
            end
          end
        end

        default: begin
          state <= sd_adma_pkg::st_stop;
        end
      endcase

      // Software clear wins over a same-cycle set
      if (int_clear) begin
        dma_int <= 2'b00;
      end
    end
  end

  // Transfer request only in the transfer state and only for a valid transfer descriptor
  a_xfer_req_in_tfr : assert property (
    @(posedge clock) disable iff (!reset)
    xfer_req |-> (state == sd_adma_pkg::st_tfr) && desc_valid && is_tran
  );

endmodule

`default_nettype wire

//--- rtl/sd_adma_pkg.sv
`default_nettype none

package sd_adma_pkg;

  ////////////////////////////////////////
  // Widths that carry a meaning
  ////////////////////////////////////////

  // System byte address and AXI data word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // Descriptor line, attributes in the low word, address in the high word
  typedef logic [63:0] desc_t;

  // Transfer length in bytes, 65536 when the length field is zero
  typedef logic [16:0] byte_len_t;

  // Word count, wide enough for a full 64 KB transfer
  typedef logic [14:0] word_cnt_t;

  // AXI arlen
  typedef logic [7:0]  burst_len_t;

  ////////////////////////////////////////
  // Descriptor layout
  ////////////////////////////////////////

  localparam int DESC_VALID_BIT = 0;
  localparam int DESC_END_BIT   = 1;
  localparam int DESC_ACT_LSB   = 4;
  localparam int DESC_ACT_W     = 2;
  localparam int DESC_LEN_LSB   = 16;
  localparam int DESC_LEN_W     = 16;
  localparam int DESC_ADDR_LSB  = 32;

  // Action codes, anything else is a no-op
  localparam logic [DESC_ACT_W-1:0] ACT_TRAN = 2'd2;
  localparam logic [DESC_ACT_W-1:0] ACT_LINK = 2'd3;

  ////////////////////////////////////////
  // Burst and block sizes
  ////////////////////////////////////////

  localparam int BURST_BEATS = 16;
  localparam int BURST_BYTES = BURST_BEATS * 4;
  localparam int DESC_BEATS  = 2;
  localparam int BLOCK_WORDS = 128;
  localparam int DESC_STRIDE = 8;

  // ADMA2 descriptor states
  typedef enum logic [1:0] {
    st_stop = 2'd0,
    st_fds  = 2'd1,
    st_cadr = 2'd2,
    st_tfr  = 2'd3
  } adma_state_t;

endpackage

`default_nettype wire

//--- rtl/sd_adma_read_master.sv
`default_nettype none

module sd_adma_read_master (
  input  wire                                       clock,
  input  wire                                       reset,
  input  wire                                       fetch_req,
  input  wire sd_adma_pkg::addr_t                   fetch_addr,
  input  wire                                       xfer_req,
  input  wire sd_adma_pkg::addr_t                   xfer_addr,
  input  wire sd_adma_pkg::byte_len_t               xfer_bytes,
  input  wire                                       arready,
  input  wire                                       rvalid,
  input  wire sd_adma_pkg::word_t                   rdata,
  input  wire                                       rlast,
  input  wire                                       fifo_ready,
  input  wire                                       ser_next_blk,
  output logic                                      done,
  output logic                                      arvalid,
  output sd_adma_pkg::addr_t                        araddr,
  output sd_adma_pkg::burst_len_t                   arlen,
  output logic                                      rready,
  output logic                                      beat_valid,
  output sd_adma_pkg::word_t                        beat_data,
  output sd_adma_pkg::word_t                        fifo_data,
  output logic                                      fifo_valid,
  output logic                                      start_write
);

  typedef enum logic [1:0] {
    rm_idle,
    rm_addr,
    rm_data,
    rm_blk_wait
  } rm_state_t;

  rm_state_t                state;
  logic                     is_fetch;
  sd_adma_pkg::word_cnt_t   words_left;
  sd_adma_pkg::word_cnt_t   blk_cnt;
  sd_adma_pkg::burst_len_t  beat_cnt;
  logic                     in_data;
  logic                     beat_take;
  logic                     last_beat;
  logic                     blk_full;

  ////////////////////////////////////////
  // R channel routing
  ////////////////////////////////////////

  assign in_data   = (state == rm_data);

  // Descriptor beats are always taken, data beats wait on the FIFO
  assign rready    = in_data && (is_fetch || fifo_ready);
  assign beat_take = rvalid && rready;
  assign last_beat = (beat_cnt == arlen);
  assign blk_full  = (blk_cnt == sd_adma_pkg::word_cnt_t'(sd_adma_pkg::BLOCK_WORDS - 1));

  assign beat_valid = in_data && is_fetch && rvalid;
  assign beat_data  = rdata;
  assign fifo_valid = in_data && !is_fetch && rvalid;
  assign fifo_data  = rdata;

  ////////////////////////////////////////
  // Burst sequencing
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state       <= rm_idle;
      is_fetch    <= 1'b0;
      arvalid     <= 1'b0;
      done        <= 1'b0;
      start_write <= 1'b0;
      words_left  <= '0;
      blk_cnt     <= '0;
      beat_cnt    <= '0;
    end else begin
      done        <= 1'b0;
      start_write <= 1'b0;

      case (state)
        rm_idle: begin
          if (fetch_req) begin
            is_fetch   <= 1'b1;
            words_left <= sd_adma_pkg::word_cnt_t'(sd_adma_pkg::DESC_BEATS);
            arvalid    <= 1'b1;
            state      <= rm_addr;
          end else if (xfer_req) begin
            is_fetch   <= 1'b0;
            words_left <= xfer_bytes[16:2];
            blk_cnt    <= '0;
            arvalid    <= 1'b1;
            state      <= rm_addr;
          end
        end

        rm_addr: begin
          if (arready) begin
            arvalid  <= 1'b0;
            beat_cnt <= '0;
            state    <= rm_data;
          end
        end

        rm_data: begin
          if (beat_take) begin
            words_left <= words_left - 1'b1;
            beat_cnt   <= beat_cnt + 1'b1;
            if (!is_fetch) begin
              blk_cnt <= blk_full ? '0 : blk_cnt + 1'b1;
            end

            if (last_beat) begin
              if (is_fetch) begin
                done  <= 1'b1;
                state <= rm_idle;
              end else if (blk_full || words_left == sd_adma_pkg::word_cnt_t'(1)) begin
                // Block complete, hand it to the serializer
                start_write <= 1'b1;
                state       <= rm_blk_wait;
              end else begin
                arvalid <= 1'b1;
                state   <= rm_addr;
              end
            end
          end
        end

        rm_blk_wait: begin
          if (ser_next_blk) begin
            if (words_left == '0) begin
              done  <= 1'b1;
              state <= rm_idle;
            end else begin
              arvalid <= 1'b1;
              state   <= rm_addr;
            end
          end
        end

        default: begin
          state <= rm_idle;
        end
      endcase
    end
  end

  // Address steps by one burst on each accept, held otherwise
  always_ff @(posedge clock) begin
    if (state == rm_idle && fetch_req) begin
      araddr <= fetch_addr;
      arlen  <= sd_adma_pkg::burst_len_t'(sd_adma_pkg::DESC_BEATS - 1);
    end else if (state == rm_idle && xfer_req) begin
      araddr <= xfer_addr;
      arlen  <= sd_adma_pkg::burst_len_t'(sd_adma_pkg::BURST_BEATS - 1);
    end else if (arvalid && arready) begin
      araddr <= araddr + sd_adma_pkg::addr_t'(sd_adma_pkg::BURST_BYTES);
    end
  end

  // Slave must end the burst exactly where arlen says
  a_rlast_on_last_beat : assert property (
    @(posedge clock) disable iff (!reset)
    (beat_take && rlast) |-> last_beat
  );

  // Descriptor length must fill whole bursts
  a_xfer_bytes_bursts : assert property (
    @(posedge clock) disable iff (!reset)
    xfer_req |-> (xfer_bytes != '0) && (xfer_bytes % sd_adma_pkg::BURST_BYTES == 0)
  );

endmodule

`default_nettype wire

//--- rtl/sd_adma_top.sv
`default_nettype none

module sd_adma_top (
  input  wire                                       clock,
  input  wire                                       reset,

  // Control
  input  wire                                       start,
  input  wire sd_adma_pkg::addr_t                   start_pointer,
  output logic [1:0]                                dma_int,
  input  wire                                       int_clear,

  // AXI read address
  output logic                                      arvalid,
  output sd_adma_pkg::addr_t                        araddr,
  output sd_adma_pkg::burst_len_t                   arlen,
  input  wire                                       arready,

  // AXI read data
  input  wire                                       rvalid,
  input  wire sd_adma_pkg::word_t                   rdata,
  input  wire                                       rlast,
  output logic                                      rready,

  // Card-side FIFO
  output sd_adma_pkg::word_t                        fifo_data,
  output logic                                      fifo_valid,
  input  wire                                       fifo_ready,

  // Serializer
  output logic                                      start_write,
  input  wire                                       ser_next_blk
);

  ////////////////////////////////////////
  // Internal connections
  ////////////////////////////////////////

  logic                                  fetch_req;
  sd_adma_pkg::addr_t                    fetch_addr;
  logic                                  xfer_req;
  sd_adma_pkg::addr_t                    xfer_addr;
  sd_adma_pkg::byte_len_t                xfer_bytes;
  logic                                  done;
  logic                                  beat_valid;
  sd_adma_pkg::word_t                    beat_data;
  logic                                  desc_valid;
  logic                                  desc_end;
  logic [sd_adma_pkg::DESC_ACT_W-1:0]    desc_act;
  sd_adma_pkg::byte_len_t                desc_len;
  sd_adma_pkg::addr_t                    desc_addr;

  // Descriptor walk and interrupts
  sd_adma_fsm u_fsm (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .start_pointer (start_pointer),
    .int_clear     (int_clear),
    .done          (done),
    .desc_valid    (desc_valid),
    .desc_end      (desc_end),
    .desc_act      (desc_act),
    .desc_len      (desc_len),
    .desc_addr     (desc_addr),
    .fetch_req     (fetch_req),
    .fetch_addr    (fetch_addr),
    .xfer_req      (xfer_req),
    .xfer_addr     (xfer_addr),
    .xfer_bytes    (xfer_bytes),
    .dma_int       (dma_int)
  );

  // Holds the fetched descriptor line
  sd_adma_desc_reg u_desc_reg (
    .clock      (clock),
    .reset      (reset),
    .fetch_req  (fetch_req),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .desc_valid (desc_valid),
    .desc_end   (desc_end),
    .desc_act   (desc_act),
    .desc_len   (desc_len),
    .desc_addr  (desc_addr)
  );

  // AXI bursts for both descriptor fetches and data
  sd_adma_read_master u_read_master (
    .clock        (clock),
    .reset        (reset),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .xfer_req     (xfer_req),
    .xfer_addr    (xfer_addr),
    .xfer_bytes   (xfer_bytes),
    .arready      (arready),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rlast        (rlast),
    .fifo_ready   (fifo_ready),
    .ser_next_blk (ser_next_blk),
    .done         (done),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .arlen        (arlen),
    .rready       (rready),
    .beat_valid   (beat_valid),
    .beat_data    (beat_data),
    .fifo_data    (fifo_data),
    .fifo_valid   (fifo_valid),
    .start_write  (start_write)
  );

endmodule

`default_nettype wire

//--- sd_adma_top.f
rtl/sd_adma_pkg.sv
rtl/sd_adma_desc_reg.sv
rtl/sd_adma_fsm.sv
rtl/sd_adma_read_master.sv
rtl/sd_adma_top.sv
verif/tb_clock_gen.sv
verif/tb_axi_mem.sv
verif/tb_checker.sv
verif/tb_sd_adma.sv

//--- verif/sd_adma_tests.txt
# test <name> <start pointer hex> <dma_int> <start_write pulses> <random fifo_ready 0/1>
# mem <byte address> <descriptor word>   fetch <descriptor address>   data <byte address> <words>
test single_xfer 00001000 1 1 0
mem 00001000 01000023
mem 00001004 00100000
fetch 00001000
data 00100000 64
run
test multi_block 00001800 1 8 0
mem 00001800 10000023
mem 00001804 00140000
fetch 00001800
data 00140000 1024
run
test link_noop 00002000 1 1 0
mem 00002000 00000001
mem 00002004 00000000
mem 00002008 00000031
mem 0000200c 00003000
mem 00003000 00800023
mem 00003004 00110000
fetch 00002000
fetch 00002008
fetch 00003000
data 00110000 32
run
test invalid_desc 00004000 2 1 0
mem 00004000 01000021
mem 00004004 00120000
mem 00004008 00000000
mem 0000400c 00000000
fetch 00004000
fetch 00004008
data 00120000 64
run
test backpressure 00005000 1 2 1
mem 00005000 04000023
mem 00005004 00130000
fetch 00005000
data 00130000 256
run

//--- verif/tb_axi_mem.sv
`default_nettype none

module tb_axi_mem (
  input  wire                           clock,
  input  wire                           arvalid,
  input  wire sd_adma_pkg::addr_t       araddr,
  input  wire sd_adma_pkg::burst_len_t  arlen,
  output logic                          arready,
  output logic                          rvalid,
  output sd_adma_pkg::word_t            rdata,
  output logic                          rlast,
  input  wire                           rready
);

  localparam int                 MAX_WORDS   = 32;
  localparam sd_adma_pkg::word_t MEM_PATTERN = 32'h5a5a_0000;

  sd_adma_pkg::addr_t      pre_addr [MAX_WORDS];
  sd_adma_pkg::word_t      pre_data [MAX_WORDS];
  int                      pre_count;
  sd_adma_pkg::addr_t      rd_addr;
  sd_adma_pkg::burst_len_t rd_len;
  sd_adma_pkg::burst_len_t rd_beat;
  sd_adma_pkg::addr_t      ar_addr_s;
  sd_adma_pkg::burst_len_t ar_len_s;
  logic                    ar_fire;
  logic                    r_fire;

  task automatic preload_word(input sd_adma_pkg::addr_t addr, input sd_adma_pkg::word_t data,
                              output bit ok);
    ok = (pre_count < MAX_WORDS);
    if (ok) begin
      pre_addr[pre_count] = addr;
      pre_data[pre_count] = data;
      pre_count++;
    end
  endtask

  task automatic clear_words();
    pre_count = 0;
  endtask

  // Preloaded descriptor words win, everything else follows the data rule
  function automatic sd_adma_pkg::word_t read_word(input sd_adma_pkg::addr_t addr);
    sd_adma_pkg::word_t value;
    value = addr ^ MEM_PATTERN;
    for (int i = 0; i < pre_count; i++) begin
      if (pre_addr[i] == addr) begin
        value = pre_data[i];
      end
    end
    return value;
  endfunction

  ////////////////////////////////////////
  // One burst at a time
  ////////////////////////////////////////

  initial begin
    arready   = 1'b1;
    rvalid    = 1'b0;
    rdata     = '0;
    rlast     = 1'b0;
    pre_count = 0;
    rd_addr   = '0;
    rd_len    = '0;
    rd_beat   = '0;
    forever begin
      // Handshakes seen just before the edge
      @(negedge clock);
      ar_fire   = arvalid && arready;
      r_fire    = rvalid && rready;
      ar_addr_s = araddr;
      ar_len_s  = arlen;
      @(posedge clock);
      #1;
      if (ar_fire) begin
        arready = 1'b0;
        rd_addr = ar_addr_s;
        rd_len  = ar_len_s;
        rd_beat = '0;
        rvalid  = 1'b1;
        rdata   = read_word(ar_addr_s);
        rlast   = (ar_len_s == '0);
      end else if (r_fire) begin
        if (rlast) begin
          rvalid  = 1'b0;
          rlast   = 1'b0;
          arready = 1'b1;
        end else begin
          rd_beat = rd_beat + 1'b1;
          rd_addr = rd_addr + 32'd4;
          rdata   = read_word(rd_addr);
          rlast   = (rd_beat == rd_len);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
`default_nettype none

module tb_checker (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           arvalid,
  input  wire sd_adma_pkg::addr_t       araddr,
  input  wire sd_adma_pkg::burst_len_t  arlen,
  input  wire                           arready,
  input  wire                           rready,
  input  wire                           fifo_valid,
  input  wire                           fifo_ready,
  input  wire sd_adma_pkg::word_t       fifo_data,
  input  wire                           start_write,
  input  wire                           ser_next_blk,
  input  wire [1:0]                     dma_int
);

  localparam sd_adma_pkg::word_t MEM_PATTERN = 32'h5a5a_0000;

  sd_adma_pkg::word_t exp_words [$];
  sd_adma_pkg::addr_t exp_fetches [$];
  sd_adma_pkg::word_t exp_word;
  sd_adma_pkg::addr_t exp_fetch;
  logic [8*24-1:0]    test_name;
  int                 exp_blocks;
  int                 blocks_seen;
  int                 words_seen;
  logic               blk_pending;
  int                 mismatch_count;
  int                 failure_count;

  initial begin
    test_name      = "none";
    exp_blocks     = 0;
    blocks_seen    = 0;
    words_seen     = 0;
    blk_pending    = 1'b0;
    mismatch_count = 0;
    failure_count  = 0;
  end

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Mismatch in test %0s, %0s: expected %h, actual %h",
             test_name, what, expected, actual);
    mismatch_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error in test %0s: %0s", test_name, msg);
    failure_count++;
  endtask

  task automatic start_test(input logic [8*24-1:0] name, input int blocks);
    test_name   = name;
    exp_blocks  = blocks;
    blocks_seen = 0;
    words_seen  = 0;
    blk_pending = 1'b0;
    exp_words.delete();
    exp_fetches.delete();
  endtask

  task automatic expect_fetch(input sd_adma_pkg::addr_t addr);
    exp_fetches.push_back(addr);
  endtask

  // Data words follow the memory rule, one per byte address step of 4
  task automatic expect_data(input sd_adma_pkg::addr_t base, input int words);
    sd_adma_pkg::addr_t addr;
    addr = base;
    repeat (words) begin
      exp_words.push_back(addr ^ MEM_PATTERN);
      addr = addr + 32'd4;
    end
  endtask

  task automatic finish_test(input logic [1:0] exp_int);
    if (exp_words.size() != 0) begin
      report_failure($sformatf("%0d FIFO words never arrived", exp_words.size()));
    end
    if (exp_fetches.size() != 0) begin
      report_failure($sformatf("%0d descriptor fetches never issued", exp_fetches.size()));
    end
    if (blocks_seen != exp_blocks) begin
      report_mismatch("start_write pulses", exp_blocks, blocks_seen);
    end
    if (dma_int !== exp_int) begin
      report_mismatch("dma_int", exp_int, dma_int);
    end
  endtask

  task automatic check_cleared();
    if (dma_int !== 2'b00) begin
      report_mismatch("dma_int after int_clear", 2'b00, dma_int);
    end
  endtask

  ////////////////////////////////////////
  // Port watch, just before each edge
  ////////////////////////////////////////

  always @(negedge clock) begin
    if (reset) begin
      // Data beats are taken only when the FIFO takes them
      if (fifo_valid && rready !== fifo_ready) begin
        report_mismatch("rready during a data burst", fifo_ready, rready);
      end

      if (fifo_valid && fifo_ready) begin
        if (exp_words.size() == 0) begin
          report_failure("FIFO word beyond the expected data");
        end else begin
          exp_word = exp_words.pop_front();
          if (fifo_data !== exp_word) begin
            report_mismatch("FIFO word", exp_word, fifo_data);
          end
          words_seen++;
          // A block closes every 128 words and on the final word
          if (words_seen % sd_adma_pkg::BLOCK_WORDS == 0 || exp_words.size() == 0) begin
            blk_pending = 1'b1;
          end
        end
      end

      if (arvalid && arready) begin
        if (blk_pending) begin
          report_failure("read address accepted before ser_next_blk");
        end
        // Two-beat bursts are descriptor fetches
        if (arlen == sd_adma_pkg::burst_len_t'(sd_adma_pkg::DESC_BEATS - 1)) begin
          if (exp_fetches.size() == 0) begin
            report_failure("descriptor fetch beyond the expected ones");
          end else begin
            exp_fetch = exp_fetches.pop_front();
            if (araddr !== exp_fetch) begin
              report_mismatch("descriptor fetch address", exp_fetch, araddr);
            end
          end
        end else if (arlen !== sd_adma_pkg::burst_len_t'(sd_adma_pkg::BURST_BEATS - 1)) begin
          report_mismatch("data burst arlen", sd_adma_pkg::BURST_BEATS - 1, arlen);
        end
      end

      if (start_write) begin
        if (!blk_pending) begin
          report_failure("start_write without a finished block");
        end
        blocks_seen++;
      end
      if (ser_next_blk) begin
        blk_pending = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 16;

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  // Active low, released just after an edge
  initial begin
    reset = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_sd_adma.sv
`default_nettype none

module tb_sd_adma;

  localparam int RESET_TIMEOUT = 100;
  localparam int INT_TIMEOUT   = 20000;
  localparam int SETTLE_CYCLES = 8;
  localparam int SER_DELAY     = 3;

  logic                    clock;
  logic                    reset;
  logic                    start;
  sd_adma_pkg::addr_t      start_pointer;
  logic [1:0]              dma_int;
  logic                    int_clear;
  logic                    arvalid;
  sd_adma_pkg::addr_t      araddr;
  sd_adma_pkg::burst_len_t arlen;
  logic                    arready;
  logic                    rvalid;
  sd_adma_pkg::word_t      rdata;
  logic                    rlast;
  logic                    rready;
  sd_adma_pkg::word_t      fifo_data;
  logic                    fifo_valid;
  logic                    fifo_ready;
  logic                    start_write;
  logic                    ser_next_blk;

  logic                    random_ready;
  logic                    timed_out;
  int                      tb_failures;
  logic [8*24-1:0]         cur_name;
  sd_adma_pkg::addr_t      cur_ptr;
  int                      cur_int;
  int                      cur_blocks;

  tb_clock_gen u_clk (
    .clock (clock),
    .reset (reset)
  );

  sd_adma_top UUT (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .start_pointer (start_pointer),
    .dma_int       (dma_int),
    .int_clear     (int_clear),
    .arvalid       (arvalid),
    .araddr        (araddr),
    .arlen         (arlen),
    .arready       (arready),
    .rvalid        (rvalid),
    .rdata         (rdata),
    .rlast         (rlast),
    .rready        (rready),
    .fifo_data     (fifo_data),
    .fifo_valid    (fifo_valid),
    .fifo_ready    (fifo_ready),
    .start_write   (start_write),
    .ser_next_blk  (ser_next_blk)
  );

  tb_axi_mem u_mem (
    .clock   (clock),
    .arvalid (arvalid),
    .araddr  (araddr),
    .arlen   (arlen),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .rlast   (rlast),
    .rready  (rready)
  );

  tb_checker u_chk (
    .clock        (clock),
    .reset        (reset),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .arlen        (arlen),
    .arready      (arready),
    .rready       (rready),
    .fifo_valid   (fifo_valid),
    .fifo_ready   (fifo_ready),
    .fifo_data    (fifo_data),
    .start_write  (start_write),
    .ser_next_blk (ser_next_blk),
    .dma_int      (dma_int)
  );

  // FIFO ready, random only in tests that ask for it
  initial begin
    int unsigned seed_val;
    seed_val   = $urandom(32'hef8e_ee31);
    fifo_ready = 1'b1;
    forever begin
      @(posedge clock);
      #1;
      fifo_ready = random_ready ? ($urandom % 4 != 0) : 1'b1;
    end
  end

  // Serializer answers each block a few cycles later
  initial begin
    ser_next_blk = 1'b0;
    forever begin
      @(negedge clock);
      if (start_write) begin
        repeat (SER_DELAY) @(posedge clock);
        #1;
        ser_next_blk = 1'b1;
        @(posedge clock);
        #1;
        ser_next_blk = 1'b0;
      end
    end
  end

  task automatic wait_for_int(output bit ok);
    int cycles;
    cycles = 0;
    while (dma_int == 2'b00 && cycles < INT_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    ok = (dma_int != 2'b00);
    @(posedge clock);
    #1;
  endtask

  task automatic run_test();
    bit ok;
    start_pointer = cur_ptr;
    start         = 1'b1;
    @(posedge clock);
    #1;
    start = 1'b0;
    wait_for_int(ok);
    if (!ok) begin
      $display("Timeout in test %0s: no interrupt within %0d cycles", cur_name, INT_TIMEOUT);
      tb_failures++;
      timed_out = 1'b1;
    end else begin
      // Quiet window, any late AR or FIFO word shows up here
      repeat (SETTLE_CYCLES) @(posedge clock);
      #1;
      u_chk.finish_test(cur_int[1:0]);
      int_clear = 1'b1;
      @(posedge clock);
      #1;
      int_clear = 1'b0;
      u_chk.check_cleared();
    end
    random_ready = 1'b0;
    u_mem.clear_words();
  endtask

  ////////////////////////////////////////
  // Test sequence from the vector file
  ////////////////////////////////////////

  initial begin
    int                 fd;
    int                 n;
    int                 cycles;
    int                 words;
    int                 rnd;
    int                 total;
    bit                 ok;
    logic [8*128-1:0]   line;
    logic [8*16-1:0]    key;
    sd_adma_pkg::addr_t addr;
    sd_adma_pkg::word_t data;

    start         = 1'b0;
    start_pointer = '0;
    int_clear     = 1'b0;
    random_ready  = 1'b0;
    timed_out     = 1'b0;
    tb_failures   = 0;

    cycles = 0;
    while (reset !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge clock);
      cycles++;
    end
    if (reset !== 1'b1) begin
      $display("Timeout: reset was never released");
      tb_failures++;
      timed_out = 1'b1;
    end
    @(posedge clock);
    #1;

    fd = $fopen("verif/sd_adma_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/sd_adma_tests.txt");
      tb_failures++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        key = '0;
        n   = $sscanf(line, "%s", key);
        if (n == 1 && key == "test") begin
          n = $sscanf(line, "%s %s %h %d %d %d", key, cur_name, cur_ptr, cur_int,
                      cur_blocks, rnd);
          random_ready = (rnd != 0);
          u_chk.start_test(cur_name, cur_blocks);
        end else if (n == 1 && key == "mem") begin
          n = $sscanf(line, "%s %h %h", key, addr, data);
          u_mem.preload_word(addr, data, ok);
          if (!ok) begin
            $display("Memory model has no room for the word at %h", addr);
            tb_failures++;
          end
        end else if (n == 1 && key == "fetch") begin
          n = $sscanf(line, "%s %h", key, addr);
          u_chk.expect_fetch(addr);
        end else if (n == 1 && key == "data") begin
          n = $sscanf(line, "%s %h %d", key, addr, words);
          u_chk.expect_data(addr, words);
        end else if (n == 1 && key == "run") begin
          run_test();
        end
      end
      $fclose(fd);
    end

    total = u_chk.mismatch_count + u_chk.failure_count + tb_failures;
    $display("Errors: %0d mismatches, %0d check failures, %0d testbench failures",
             u_chk.mismatch_count, u_chk.failure_count, tb_failures);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
